// File: hw/pic_pkg.sv
/*
 * Shared widths, bus and configuration structs, and state and command
 * enums for the 8086-mode interrupt controller. Every design file refers
 * to these by scoped names.
 */
package pic_pkg;

    localparam int NUM_IRQ = 8;
    localparam int LEVEL_W = 3;
    localparam int DATA_W = 8;
    localparam logic [LEVEL_W-1:0] SPURIOUS_LEVEL = 3'd7;

    // One host cycle, wr and rd last a single clock
    typedef struct packed {
        logic              wr;
        logic              rd;
        logic              a0;
        logic [DATA_W-1:0] data;
    } host_bus_t;

    typedef struct packed {
        logic [DATA_W-LEVEL_W-1:0] vector_base;
        logic                      level_mode;
        logic                      auto_eoi;
        logic [NUM_IRQ-1:0]        imr;
        logic                      read_isr;
        logic                      ready;
    } pic_config_t;

    typedef struct packed {
        logic               valid;
        logic               specific;
        logic [LEVEL_W-1:0] level;
    } eoi_cmd_t;

    typedef enum logic [1:0] {
        INIT_ICW2,
        INIT_ICW4,
        INIT_READY
    } init_state_t;

    typedef enum logic [1:0] {
        ACK_IDLE,
        ACK_FIRST,
        ACK_GAP,
        ACK_SECOND
    } ack_state_t;

    // OCW2 bits 7..5, codes not listed here are ignored
    typedef enum logic [2:0] {
        OP_NONSPEC_EOI = 3'b001,
        OP_SPEC_EOI    = 3'b011
    } eoi_op_t;

endpackage

// File: hw/pic_cmd_decode.sv
`timescale 1ns/1ns
/*
 * Host command decode. Runs the ICW1/ICW2/ICW4 initialization sequence,
 * holds the configuration registers (mask, trigger mode, vector base,
 * read select) and turns OCW2 writes into single-cycle EOI commands.
 */
module pic_cmd_decode (
    input  logic                 clock,
    input  logic                 reset,
    input  pic_pkg::host_bus_t   bus,
    output pic_pkg::pic_config_t cfg,
    output pic_pkg::eoi_cmd_t    eoi,
    output logic                 init_clear
);

    pic_pkg::init_state_t state;
    pic_pkg::init_state_t state_next;
    pic_pkg::eoi_op_t     eoi_op;

    logic                                        icw1_seen;
    logic                                        ic4;
    logic [pic_pkg::DATA_W-pic_pkg::LEVEL_W-1:0] vector_base;
    logic                                        level_mode;
    logic                                        auto_eoi;
    logic [pic_pkg::NUM_IRQ-1:0]                 imr;
    logic                                        read_isr;

    logic icw1_wr;
    logic icw_wr;
    logic ocw1_wr;
    logic ocw2_wr;
    logic ocw3_wr;

    assign icw1_wr = bus.wr && !bus.a0 && bus.data[4];
    // ICW2/ICW4 only count once an ICW1 has opened the sequence
    assign icw_wr  = bus.wr && bus.a0 && icw1_seen && (state != pic_pkg::INIT_READY);
    assign ocw1_wr = bus.wr && bus.a0 && (state == pic_pkg::INIT_READY);
    assign ocw2_wr = bus.wr && !bus.a0 && !bus.data[4] && !bus.data[3]
                     && (state == pic_pkg::INIT_READY);
    assign ocw3_wr = bus.wr && !bus.a0 && !bus.data[4] && bus.data[3]
                     && (state == pic_pkg::INIT_READY);

    assign init_clear = icw1_wr;
    assign eoi_op = pic_pkg::eoi_op_t'(bus.data[7:5]);

    always_comb begin
        state_next = state;
        if (icw1_wr) begin
            state_next = pic_pkg::INIT_ICW2;
        end else if (icw_wr) begin
            case (state)
                pic_pkg::INIT_ICW2: state_next = ic4 ? pic_pkg::INIT_ICW4 : pic_pkg::INIT_READY;
                pic_pkg::INIT_ICW4: state_next = pic_pkg::INIT_READY;
                default:            state_next = state;
            endcase
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state       <= pic_pkg::INIT_ICW2;
            icw1_seen   <= 1'b0;
            ic4         <= 1'b0;
            vector_base <= '0;
            level_mode  <= 1'b0;
            auto_eoi    <= 1'b0;
            imr         <= '1;
            read_isr    <= 1'b0;
        end else begin
            state <= state_next;
            if (icw1_wr) begin
                // LTIM and IC4, everything else back to defaults
                icw1_seen  <= 1'b1;
                ic4        <= bus.data[0];
                level_mode <= bus.data[3];
                auto_eoi   <= 1'b0;
                imr        <= '0;
                read_isr   <= 1'b0;
            end else begin
                if (icw_wr && state == pic_pkg::INIT_ICW2)
                    vector_base <= bus.data[7:3];
                if (icw_wr && state == pic_pkg::INIT_ICW4)
                    auto_eoi <= bus.data[1];
                if (ocw1_wr)
                    imr <= bus.data;
                // RR selects, RIS picks ISR over IRR
                if (ocw3_wr && bus.data[1])
                    read_isr <= bus.data[0];
            end
        end
    end

    always_comb begin
        cfg.vector_base = vector_base;
        cfg.level_mode  = level_mode;
        cfg.auto_eoi    = auto_eoi;
        cfg.imr         = imr;
        cfg.read_isr    = read_isr;
        cfg.ready       = (state == pic_pkg::INIT_READY);
    end

    always_comb begin
        eoi.valid    = 1'b0;
        eoi.specific = 1'b0;
        eoi.level    = bus.data[pic_pkg::LEVEL_W-1:0];
        if (ocw2_wr) begin
            case (eoi_op)
                pic_pkg::OP_NONSPEC_EOI: eoi.valid = 1'b1;
                pic_pkg::OP_SPEC_EOI: begin
                    eoi.valid    = 1'b1;
                    eoi.specific = 1'b1;
                end
                default: eoi.valid = 1'b0;
            endcase
        end
    end

endmodule

// File: hw/pic_request_reg.sv
`timescale 1ns/1ns
/*
 * Interrupt request register. Captures ir by rising edge or by level,
 * drops the acknowledged bit on ack_latch and clears on ICW1.
 */
module pic_request_reg (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [pic_pkg::NUM_IRQ-1:0]   ir,
    input  pic_pkg::pic_config_t          cfg,
    input  logic                          init_clear,
    input  logic                          ack_latch,
    input  logic [pic_pkg::LEVEL_W-1:0]   ack_level,
    output logic [pic_pkg::NUM_IRQ-1:0]   irr
);

    logic [pic_pkg::NUM_IRQ-1:0] ir_prev;
    logic [pic_pkg::NUM_IRQ-1:0] ir_rise;
    logic [pic_pkg::NUM_IRQ-1:0] ack_mask;

    assign ir_rise  = ir & ~ir_prev;
    assign ack_mask = ack_latch ? (pic_pkg::NUM_IRQ'(1) << ack_level) : '0;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ir_prev <= '0;
            irr     <= '0;
        end else begin
            ir_prev <= ir;
            if (init_clear)
                irr <= '0;
            else if (cfg.level_mode)
                irr <= ir & ~ack_mask;
            else
                irr <= (irr | ir_rise) & ~ack_mask;
        end
    end

endmodule

// File: hw/pic_priority_service.sv
`timescale 1ns/1ns
/*
 * Fixed-priority resolver and in-service register. IR0 wins. A request
 * is granted only above every level already in service. ISR bits are set
 * on acknowledge and cleared by OCW2 EOI or automatic EOI.
 */
module pic_priority_service (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [pic_pkg::NUM_IRQ-1:0]   irr,
    input  pic_pkg::pic_config_t          cfg,
    input  pic_pkg::eoi_cmd_t             eoi,
    input  logic                          ack_latch,
    input  logic [pic_pkg::LEVEL_W-1:0]   ack_level,
    input  logic                          auto_eoi,
    input  logic                          init_clear,
    output logic [pic_pkg::NUM_IRQ-1:0]   grant,
    output logic [pic_pkg::NUM_IRQ-1:0]   isr
);

    logic [pic_pkg::NUM_IRQ-1:0] masked;
    logic [pic_pkg::NUM_IRQ-1:0] isr_next;
    logic [pic_pkg::LEVEL_W-1:0] req_level;
    logic [pic_pkg::LEVEL_W-1:0] svc_level;
    logic                        in_service;

    assign masked     = irr & ~cfg.imr;
    assign in_service = |isr;

    // Lowest index wins, so scan downwards and keep the last hit
    always_comb begin
        req_level = '0;
        svc_level = '0;
        for (int i = pic_pkg::NUM_IRQ - 1; i >= 0; i--) begin
            if (masked[i])
                req_level = pic_pkg::LEVEL_W'(i);
            if (isr[i])
                svc_level = pic_pkg::LEVEL_W'(i);
        end
    end

    always_comb begin
        grant = '0;
        if (|masked && (!in_service || req_level < svc_level))
            grant = pic_pkg::NUM_IRQ'(1) << req_level;
    end

    always_comb begin
        isr_next = isr;
        // Spurious acknowledge has no grant bit at ack_level
        if (ack_latch && grant[ack_level])
            isr_next[ack_level] = 1'b1;
        if (auto_eoi)
            isr_next[ack_level] = 1'b0;
        if (eoi.valid) begin
            if (eoi.specific)
                isr_next[eoi.level] = 1'b0;
            else if (in_service)
                isr_next[svc_level] = 1'b0;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset)
            isr <= '0;
        else if (init_clear)
            isr <= '0;
        else
            isr <= isr_next;
    end

endmodule

// File: hw/pic_ack_fsm.sv
`timescale 1ns/1ns
/*
 * INTA sequence for 8086 mode. Raises INT on a grant, latches the level on
 * the first INTA pulse and drives the vector during the second. Outside
 * the vector drive it answers host reads with IMR, IRR or ISR.
 */
module pic_ack_fsm (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          inta_n,
    input  pic_pkg::host_bus_t            bus,
    input  pic_pkg::pic_config_t          cfg,
    input  logic [pic_pkg::NUM_IRQ-1:0]   grant,
    input  logic [pic_pkg::NUM_IRQ-1:0]   irr,
    input  logic [pic_pkg::NUM_IRQ-1:0]   isr,
    output logic                          intr,
    output logic                          ack_latch,
    output logic [pic_pkg::LEVEL_W-1:0]   ack_level,
    output logic                          auto_eoi,
    output logic [pic_pkg::DATA_W-1:0]    data_out,
    output logic                          data_en
);

    pic_pkg::ack_state_t state;
    pic_pkg::ack_state_t state_next;

    logic                        inta_q;
    logic                        inta_prev;
    logic                        inta_fall;
    logic                        inta_rise;
    logic [pic_pkg::LEVEL_W-1:0] grant_level;
    logic [pic_pkg::LEVEL_W-1:0] level_q;
    logic                        spurious_q;

    assign inta_fall = inta_prev & ~inta_q;
    assign inta_rise = ~inta_prev & inta_q;

    always_comb begin
        grant_level = pic_pkg::SPURIOUS_LEVEL;
        for (int i = pic_pkg::NUM_IRQ - 1; i >= 0; i--) begin
            if (grant[i])
                grant_level = pic_pkg::LEVEL_W'(i);
        end
    end

    // Pulses ignored until initialization is done
    assign ack_latch = (state == pic_pkg::ACK_IDLE) && inta_fall && cfg.ready;
    assign ack_level = ack_latch ? grant_level : level_q;
    assign auto_eoi  = (state == pic_pkg::ACK_SECOND) && inta_rise && cfg.auto_eoi
                       && !spurious_q;

    always_comb begin
        state_next = state;
        case (state)
            pic_pkg::ACK_IDLE:   if (ack_latch) state_next = pic_pkg::ACK_FIRST;
            pic_pkg::ACK_FIRST:  if (inta_rise) state_next = pic_pkg::ACK_GAP;
            pic_pkg::ACK_GAP:    if (inta_fall) state_next = pic_pkg::ACK_SECOND;
            pic_pkg::ACK_SECOND: if (inta_rise) state_next = pic_pkg::ACK_IDLE;
            default:             state_next = pic_pkg::ACK_IDLE;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state     <= pic_pkg::ACK_IDLE;
            inta_q    <= 1'b1;
            inta_prev <= 1'b1;
            intr      <= 1'b0;
        end else begin
            state     <= state_next;
            inta_q    <= inta_n;
            inta_prev <= inta_q;
            intr      <= (state == pic_pkg::ACK_IDLE) && !ack_latch && cfg.ready && |grant;
        end
    end

    always_ff @(posedge clock) begin
        if (ack_latch) begin
            level_q    <= grant_level;
            spurious_q <= ~|grant;
        end
    end

    // Vector drive takes priority; reads held off in the first pulse
    always_comb begin
        data_en  = 1'b0;
        data_out = '0;
        if (state == pic_pkg::ACK_SECOND && !inta_n) begin
            data_en  = 1'b1;
            data_out = {cfg.vector_base, level_q};
        end else if (bus.rd && state != pic_pkg::ACK_FIRST) begin
            data_en = 1'b1;
            if (bus.a0)
                data_out = cfg.imr;
            else if (cfg.read_isr)
                data_out = isr;
            else
                data_out = irr;
        end
    end

endmodule

// File: hw/pic_top.sv
`timescale 1ns/1ns
/*
 * Top level of the single-device 8086-mode interrupt controller.
 * Connects command decode, request register, priority and ISR, and the
 * acknowledge sequencer.
 */
module pic_top (
    input  logic                          clock,
    input  logic                          reset,
    input  pic_pkg::host_bus_t            bus,
    input  logic [pic_pkg::NUM_IRQ-1:0]   ir,
    input  logic                          inta_n,
    output logic                          intr,
    output logic [pic_pkg::DATA_W-1:0]    data_out,
    output logic                          data_en
);

    pic_pkg::pic_config_t        cfg;
    pic_pkg::eoi_cmd_t           eoi;
    logic                        init_clear;
    logic [pic_pkg::NUM_IRQ-1:0] irr;
    logic [pic_pkg::NUM_IRQ-1:0] isr;
    logic [pic_pkg::NUM_IRQ-1:0] grant;
    logic                        ack_latch;
    logic [pic_pkg::LEVEL_W-1:0] ack_level;
    logic                        auto_eoi;

    pic_cmd_decode i_cmd_decode (
        .clock      (clock),
        .reset      (reset),
        .bus        (bus),
        .cfg        (cfg),
        .eoi        (eoi),
        .init_clear (init_clear)
    );

    pic_request_reg i_request_reg (
        .clock      (clock),
        .reset      (reset),
        .ir         (ir),
        .cfg        (cfg),
        .init_clear (init_clear),
        .ack_latch  (ack_latch),
        .ack_level  (ack_level),
        .irr        (irr)
    );

    pic_priority_service i_priority_service (
        .clock      (clock),
        .reset      (reset),
        .irr        (irr),
        .cfg        (cfg),
        .eoi        (eoi),
        .ack_latch  (ack_latch),
        .ack_level  (ack_level),
        .auto_eoi   (auto_eoi),
        .init_clear (init_clear),
        .grant      (grant),
        .isr        (isr)
    );

    pic_ack_fsm i_ack_fsm (
        .clock      (clock),
        .reset      (reset),
        .inta_n     (inta_n),
        .bus        (bus),
        .cfg        (cfg),
        .grant      (grant),
        .irr        (irr),
        .isr        (isr),
        .intr       (intr),
        .ack_latch  (ack_latch),
        .ack_level  (ack_level),
        .auto_eoi   (auto_eoi),
        .data_out   (data_out),
        .data_en    (data_en)
    );

endmodule

// File: dv/pic_asserts.sv
`timescale 1ns/1ns
/*
 * Concurrent checks on the INTA sequencer, bound into pic_ack_fsm.
 */
module pic_asserts (
    input logic                clock,
    input logic                reset,
    input pic_pkg::ack_state_t state,
    input logic                data_en,
    input logic                intr,
    input logic                ack_latch
);

    // No bus drive while the level is being latched
    no_drive_first_pulse: assert property (@(posedge clock) disable iff (reset)
        state == pic_pkg::ACK_FIRST |-> !data_en)
        else $error("data bus driven during the first INTA pulse");

    intr_drops_after_ack: assert property (@(posedge clock) disable iff (reset)
        ack_latch |=> !intr)
        else $error("intr still high in the cycle after ack_latch");

    single_cycle_ack: assert property (@(posedge clock) disable iff (reset)
        ack_latch |=> !ack_latch)
        else $error("ack_latch held for more than one cycle");

endmodule

bind pic_ack_fsm pic_asserts i_asserts (
    .clock     (clock),
    .reset     (reset),
    .state     (state),
    .data_en   (data_en),
    .intr      (intr),
    .ack_latch (ack_latch)
);

// File: dv/pic_tb.sv
`timescale 1ns/1ns
/*
 * Testbench for the 8086-mode interrupt controller. Drives seeded random
 * host cycles, request patterns and INTA pulses, and checks reads, vectors
 * and INT against a register-level model of IRR, ISR, IMR and the config.
 */
module pic_tb;

    // Rough per-test budgets in cycles
    localparam int TEST_CYCLES = 8 * 40 + 12 * 60 + 4 * 24 * 50 + 4 * 90 + 4 * 90;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 500;

    logic                          clock;
    logic                          reset;
    pic_pkg::host_bus_t            bus;
    logic [pic_pkg::NUM_IRQ-1:0]   ir;
    logic                          inta_n;
    logic                          intr;
    logic [pic_pkg::DATA_W-1:0]    data_out;
    logic                          data_en;

    // Reference model
    logic [7:0] m_irr;
    logic [7:0] m_isr;
    logic [7:0] m_imr;
    logic [4:0] m_base;
    logic       m_level;
    logic       m_aeoi;
    logic       m_read_isr;

    integer seed;
    int     cycle_count;
    int     check_count;
    int     error_count;
    int     test_count;
    int     errors_before;
    logic [7:0] mask;
    logic [7:0] req;

    pic_top i_dut (
        .clock    (clock),
        .reset    (reset),
        .bus      (bus),
        .ir       (ir),
        .inta_n   (inta_n),
        .intr     (intr),
        .data_out (data_out),
        .data_en  (data_en)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("MISMATCH %s got %h expected %h", name, got, expected);
        end
    endtask

    // Fixed priority, IR0 highest, blocked by anything in service at or above
    function automatic int resolve_grant(input logic [7:0] pending, input logic [7:0] masked,
                                         input logic [7:0] service);
        int req_lvl;
        int svc_lvl;
        req_lvl = -1;
        svc_lvl = 8;
        for (int i = 7; i >= 0; i--) begin
            if (pending[3'(i)] && !masked[3'(i)])
                req_lvl = i;
            if (service[3'(i)])
                svc_lvl = i;
        end
        if (req_lvl >= 0 && req_lvl < svc_lvl)
            return req_lvl;
        return -1;
    endfunction

    task automatic write_reg(input logic a0, input logic [7:0] value);
        @(negedge clock);
        bus = '{wr: 1'b1, rd: 1'b0, a0: a0, data: value};
        @(negedge clock);
        bus = '0;
    endtask

    task automatic read_check(input logic a0, input string name, input logic [7:0] expected);
        @(negedge clock);
        bus = '{wr: 1'b0, rd: 1'b1, a0: a0, data: 8'h00};
        #1;
        check_value({name, " data_en"}, 32'(data_en), 32'd1);
        check_value(name, 32'(data_out), 32'(expected));
        @(negedge clock);
        bus = '0;
    endtask

    task automatic check_status();
        read_check(1'b1, "imr", m_imr);
        if (m_read_isr)
            read_check(1'b0, "isr", m_isr);
        else
            read_check(1'b0, "irr", m_irr);
    endtask

    task automatic set_requests(input logic [7:0] value);
        @(negedge clock);
        if (m_level)
            m_irr = value;
        else
            m_irr = m_irr | (value & ~ir);
        ir = value;
        @(negedge clock);
    endtask

    task automatic init_pic(input logic ltim, input logic ic4, input logic aeoi);
        logic [7:0] icw;
        icw = (8'($random(seed)) & 8'he6) | 8'h10 | {4'b0000, ltim, 2'b00, ic4};
        write_reg(1'b0, icw);
        m_level = ltim;
        m_aeoi = 1'b0;
        m_imr = 8'h00;
        m_isr = 8'h00;
        m_irr = ltim ? ir : 8'h00;
        m_read_isr = 1'b0;
        icw = 8'($random(seed));
        write_reg(1'b1, icw);
        m_base = icw[7:3];
        if (ic4) begin
            icw = (8'($random(seed)) & 8'hfd) | {6'b000000, aeoi, 1'b0};
            write_reg(1'b1, icw);
            m_aeoi = aeoi;
        end
    endtask

    task automatic set_mask(input logic [7:0] value);
        write_reg(1'b1, value);
        m_imr = value;
    endtask

    task automatic select_read(input logic ris);
        write_reg(1'b0, {7'b0000101, ris});
        m_read_isr = ris;
    endtask

    task automatic send_eoi(input logic specific, input logic [2:0] level);
        int lvl;
        lvl = -1;
        write_reg(1'b0, specific ? {3'b011, 2'b00, level} : 8'h20);
        if (specific) begin
            m_isr[level] = 1'b0;
        end else begin
            for (int i = 7; i >= 0; i--) begin
                if (m_isr[3'(i)])
                    lvl = i;
            end
            if (lvl >= 0)
                m_isr[3'(lvl)] = 1'b0;
        end
        @(negedge clock);
        check_value("intr after eoi", 32'(intr), 32'(resolve_grant(m_irr, m_imr, m_isr) >= 0));
    endtask

    task automatic wait_intr();
        int waited;
        waited = 0;
        while (!intr && waited < 20) begin
            @(negedge clock);
            waited++;
        end
        if (!intr) begin
            error_count++;
            $display("ERROR: intr did not rise within 20 cycles of a pending request");
        end
    endtask

    task automatic inta_pulse(output logic [7:0] vec, output logic en);
        @(negedge clock);
        inta_n = 1'b0;
        repeat (3) @(negedge clock);
        #1;
        vec = data_out;
        en = data_en;
        @(negedge clock);
        inta_n = 1'b1;
        repeat (3) @(negedge clock);
    endtask

    task automatic acknowledge();
        int         lvl;
        logic [2:0] ack_lvl;
        logic [7:0] vec;
        logic       en;
        lvl = resolve_grant(m_irr, m_imr, m_isr);
        ack_lvl = (lvl >= 0) ? 3'(lvl) : pic_pkg::SPURIOUS_LEVEL;
        inta_pulse(vec, en);
        check_value("data_en first pulse", 32'(en), 32'd0);
        if (lvl >= 0)
            m_isr[ack_lvl] = 1'b1;
        m_irr[ack_lvl] = 1'b0;
        inta_pulse(vec, en);
        check_value("data_en second pulse", 32'(en), 32'd1);
        check_value("vector", 32'(vec), 32'({m_base, ack_lvl}));
        if (m_aeoi && lvl >= 0)
            m_isr[ack_lvl] = 1'b0;
        if (m_level)
            m_irr = ir;
        check_value("intr after ack", 32'(intr), 32'(resolve_grant(m_irr, m_imr, m_isr) >= 0));
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %s finished with %0d errors", test_count, name,
                 error_count - errors_before);
        errors_before = error_count;
    endtask

    initial begin
        seed = 32'h3601fc03;
        reset = 1'b1;
        bus = '0;
        ir = '0;
        inta_n = 1'b1;
        m_irr = 8'h00;
        m_isr = 8'h00;
        m_imr = 8'hff;
        m_base = 5'd0;
        m_level = 1'b0;
        m_aeoi = 1'b0;
        m_read_isr = 1'b0;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        test_count = 0;
        errors_before = 0;
        repeat (5) @(negedge clock);
        reset = 1'b0;

        // Init sequences and status reads
        read_check(1'b1, "imr after reset", 8'hff);
        repeat (8) begin
            set_requests(8'h00);
            init_pic(1'($random(seed)), 1'($random(seed)), 1'($random(seed)));
            set_mask(8'($random(seed)));
            set_requests(8'($random(seed)));
            select_read(1'($random(seed)));
            check_status();
            select_read(~m_read_isr);
            check_status();
        end
        report_test("init and reads");

        // Edge-triggered priority and vector
        set_requests(8'h00);
        init_pic(1'b0, 1'($random(seed)), 1'b0);
        select_read(1'b1);
        repeat (12) begin
            mask = 8'($random(seed));
            mask[3'($random(seed))] = 1'b0;
            req = 8'($random(seed));
            if ((req & ~mask) == 8'h00)
                req = ~mask;
            set_mask(mask);
            set_requests(8'h00);
            set_requests(req);
            wait_intr();
            acknowledge();
            check_status();
            send_eoi(1'b0, 3'd0);
        end
        report_test("edge priority and ack");

        // Nested service with random EOIs
        set_requests(8'h00);
        init_pic(1'b0, 1'b0, 1'b0);
        select_read(1'b1);
        repeat (4) begin
            req = 8'($random(seed));
            if (req == 8'h00)
                req = 8'h80;
            set_requests(8'h00);
            set_requests(req);
            for (int step = 0; step < 24; step++) begin
                if (resolve_grant(m_irr, m_imr, m_isr) >= 0) begin
                    wait_intr();
                    acknowledge();
                end else if (m_isr != 8'h00) begin
                    send_eoi(1'($random(seed)), 3'($random(seed)));
                    check_status();
                end
            end
        end
        report_test("end of interrupt");

        // Level mode with automatic EOI, a held request comes back
        set_requests(8'h00);
        init_pic(1'b1, 1'b1, 1'b1);
        select_read(1'b1);
        repeat (4) begin
            req = 8'($random(seed));
            if (req == 8'h00)
                req = 8'h10;
            set_requests(req);
            wait_intr();
            acknowledge();
            check_status();
            wait_intr();
            acknowledge();
            check_status();
            set_requests(8'h00);
        end
        report_test("auto eoi and level mode");

        // Acknowledge with nothing granted
        init_pic(1'b0, 1'b0, 1'b0);
        select_read(1'b1);
        repeat (4) begin
            set_requests(8'h00);
            set_requests(8'($random(seed)));
            set_mask(8'hff);
            acknowledge();
            check_status();
            set_mask(8'h00);
            if (resolve_grant(m_irr, m_imr, m_isr) >= 0)
                wait_intr();
            acknowledge();
            check_status();
        end
        report_test("spurious ack");

        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
        if (error_count == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

// File: files.f
hw/pic_pkg.sv
hw/pic_cmd_decode.sv
hw/pic_request_reg.sv
hw/pic_priority_service.sv
hw/pic_ack_fsm.sv
hw/pic_top.sv
dv/pic_asserts.sv
dv/pic_tb.sv

// File: run.sh
#!/bin/sh
# Build the interrupt controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module pic_tb -o pic_sim

# Pass only if the run prints the pass line
./obj_dir/pic_sim | tee /dev/stderr | grep -q -x "TEST PASS"
echo "simulation passed"
